/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = tb_rammodel
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+verilog
verilog/rammodel_pkg.sv
verilog/rammodel_req_if.sv
verilog/ready_valid_fork.sv
verilog/rammodel_delay_queue.sv
verilog/rammodel_timing_fixed.sv
verilog/rammodel_tracker.sv
verilog/rammodel_frontend.sv
verilog/rammodel_backend.sv
verilog/rammodel_top.sv
tests/tb_rammodel.sv

/* tests/tb_rammodel.sv */
`timescale 1ns/1ps
`include "rammodel_consts.svh"

module tb_rammodel import rammodel_pkg::*; ();

    localparam int N_TESTS = 5;
    localparam int TIMEOUT = N_TESTS * 200 + 1000; // cycles
    localparam int BYTES   = `RAMMODEL_DATA_W / 8;
    localparam int CH_AW   = 0;
    localparam int CH_W    = 1;
    localparam int CH_AR   = 2;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic       i_clk, i_rst_n;
    logic       i_awvalid, o_awready;
    axi_id_t    i_awid;
    axi_addr_t  i_awaddr;
    axi_len_t   i_awlen;
    logic [2:0] i_awsize;
    logic [1:0] i_awburst;
    logic       i_wvalid, o_wready;
    axi_data_t  i_wdata;
    axi_strb_t  i_wstrb;
    logic       i_wlast;
    logic       o_bvalid, i_bready;
    axi_id_t    o_bid;
    logic [1:0] o_bresp;
    logic       i_arvalid, o_arready;
    axi_id_t    i_arid;
    axi_addr_t  i_araddr;
    axi_len_t   i_arlen;
    logic [2:0] i_arsize;
    logic [1:0] i_arburst;
    logic       o_rvalid, i_rready;
    axi_id_t    o_rid;
    axi_data_t  o_rdata;
    logic [1:0] o_rresp;
    logic       o_rlast;

    int          errors;
    logic [15:0] lfsr;
    axi_data_t   shadow [`RAMMODEL_MEM_WORDS]; // expected store contents
    axi_data_t   beat_data [4];
    axi_strb_t   beat_strb [4];

    rammodel_top rammodel_top_i (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr); // one step per bit
        end
        return v;
    endfunction

    // word index of a full width INCR beat wraps with the store
    function automatic int word_of(input axi_addr_t addr, input int beat);
        return (int'(addr) / BYTES + beat) % `RAMMODEL_MEM_WORDS;
    endfunction

    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    // samples ready mid-cycle and returns just after the handshake edge
    task automatic wait_accept(input int chan);
        logic rdy;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge i_clk);
            case (chan)
                CH_AW:   rdy = o_awready;
                CH_W:    rdy = o_wready;
                default: rdy = o_arready;
            endcase
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               output int lat);
        i_awid    = id;
        i_awaddr  = addr;
        i_awlen   = len;
        i_awvalid = 1'b1;
        wait_accept(CH_AW);
        i_awvalid = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            i_wdata  = beat_data[b];
            i_wstrb  = beat_strb[b];
            i_wlast  = (b == int'(len));
            i_wvalid = 1'b1;
            wait_accept(CH_W);
            for (int k = 0; k < BYTES; k++) begin
                if (beat_strb[b][k]) shadow[word_of(addr, b)][8*k +: 8] = beat_data[b][8*k +: 8];
            end
        end
        i_wvalid = 1'b0;
        i_wlast  = 1'b0;
        lat = 0;
        do begin
            @(negedge i_clk);
            lat++;
        end while (!o_bvalid);
        check_id("o_bid", id, o_bid);
        check_resp("o_bresp", RESP_OKAY, o_bresp);
        @(posedge i_clk);
        #1;
    endtask

    // hold > 0 keeps rready low for that many cycles of a waiting beat
    task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input int hold, output int lat);
        int        beat;
        int        stalls;
        logic      seen;
        beat      = 0;
        stalls    = 0;
        seen      = 1'b0;
        lat       = 0;
        i_arid    = id;
        i_araddr  = addr;
        i_arlen   = len;
        i_arvalid = 1'b1;
        i_rready  = (hold == 0);
        wait_accept(CH_AR);
        i_arvalid = 1'b0;
        while (beat <= int'(len)) begin
            @(negedge i_clk);
            if (!seen) lat++;
            if (seen && !o_rvalid) begin
                $display("read burst %0h: rvalid dropped before the last beat", id);
                errors++;
            end
            if (o_rvalid && !i_rready) begin
                // stalled beat keeps its final id and data
                check_id("o_rid", id, o_rid);
                check_data("o_rdata", shadow[word_of(addr, beat)], o_rdata);
                stalls++;
            end else if (o_rvalid) begin
                check_id("o_rid", id, o_rid);
                check_data("o_rdata", shadow[word_of(addr, beat)], o_rdata);
                check_resp("o_rresp", RESP_OKAY, o_rresp);
                check_flag("o_rlast", beat == int'(len), o_rlast);
                beat++;
            end
            seen = seen || o_rvalid;
            @(posedge i_clk);
            #1;
            if (stalls >= hold) i_rready = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_single_rw();
        int lat;
        beat_data[0] = rand_bits(64);
        beat_strb[0] = '1;
        write_burst(4'h3, 16'h0080, 8'd0, lat);
        read_burst(4'h5, 16'h0080, 8'd0, 0, lat);
    endtask

    task automatic test_latency();
        int lat;
        beat_data[0] = rand_bits(64);
        beat_strb[0] = '1;
        write_burst(4'h2, 16'h0088, 8'd0, lat);
        check_cycles("bvalid latency", `RAMMODEL_W_DELAY, lat);
        read_burst(4'h4, 16'h0088, 8'd0, 0, lat);
        check_cycles("rvalid latency", `RAMMODEL_R_DELAY, lat);
    endtask

    task automatic test_burst_strobes();
        int lat;
        for (int b = 0; b < 4; b++) begin
            beat_data[b] = rand_bits(64);
            beat_strb[b] = '1;
        end
        write_burst(4'h6, 16'h0100, 8'd3, lat);
        for (int b = 0; b < 4; b++) begin
            beat_data[b] = rand_bits(64);
            beat_strb[b] = axi_strb_t'(rand_bits(BYTES)); // partial merge
        end
        write_burst(4'h7, 16'h0100, 8'd3, lat);
        read_burst(4'h8, 16'h0100, 8'd3, 0, lat);
    endtask

    task automatic test_backpressure();
        int lat;
        read_burst(4'h9, 16'h0100, 8'd3, 10, lat);
    endtask

    task automatic test_inflight();
        axi_addr_t addrs [5];
        int        issued;
        int        got;
        logic      rdy;
        addrs  = '{16'h0080, 16'h0088, 16'h0100, 16'h0108, 16'h0110};
        issued = 0;
        got    = 0;
        fork
            begin
                for (int k = 0; k < 5; k++) begin
                    i_arid    = axi_id_t'(k + 1);
                    i_araddr  = addrs[k];
                    i_arlen   = '0;
                    i_arvalid = 1'b1; // stays high between bursts
                    rdy       = 1'b0;
                    while (!rdy) begin
                        @(negedge i_clk);
                        rdy = o_arready;
                        check_flag("o_arready", (issued - got) < `RAMMODEL_MAX_INFLIGHT, rdy);
                        @(posedge i_clk);
                        #1;
                    end
                    issued++;
                end
                i_arvalid = 1'b0;
            end
            begin
                for (int k = 0; k < 5; k++) begin
                    do begin
                        @(negedge i_clk);
                    end while (!o_rvalid);
                    check_id("o_rid", axi_id_t'(k + 1), o_rid); // issue order
                    check_data("o_rdata", shadow[word_of(addrs[k], 0)], o_rdata);
                    check_flag("o_rlast", 1'b1, o_rlast);
                    @(posedge i_clk);
                    #1;
                    got++;
                end
            end
        join
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, watchdog, sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        repeat (TIMEOUT) @(posedge i_clk);
        $display("timeout: the DUT stopped responding, run ended after %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        errors    = 0;
        lfsr      = 16'd65;
        i_rst_n   = 1'b0;
        i_awvalid = 1'b0;
        i_awid    = '0;
        i_awaddr  = '0;
        i_awlen   = '0;
        i_awsize  = 3'd3; // 8 bytes per beat
        i_awburst = 2'b01;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_wlast   = 1'b0;
        i_bready  = 1'b1;
        i_arvalid = 1'b0;
        i_arid    = '0;
        i_araddr  = '0;
        i_arlen   = '0;
        i_arsize  = 3'd3;
        i_arburst = 2'b01;
        i_rready  = 1'b1;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        check_flag("o_awready", 1'b0, o_awready);
        check_flag("o_arready", 1'b0, o_arready);
        check_flag("o_wready", 1'b0, o_wready);
        check_flag("o_bvalid", 1'b0, o_bvalid);
        check_flag("o_rvalid", 1'b0, o_rvalid);
        @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        test_single_rw();
        test_latency();
        test_burst_strobes();
        test_backpressure();
        test_inflight();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/rammodel_backend.sv */
`timescale 1ns/1ps
`include "rammodel_consts.svh"

module rammodel_backend import rammodel_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    rammodel_req_if.backend req
);

    localparam int WA = $clog2(`RAMMODEL_MEM_WORDS);
    localparam int OFF = $clog2(`RAMMODEL_DATA_W / 8);
    localparam int SB = `RAMMODEL_DATA_W / 8;
    // tracker may run one burst ahead of the completed responses
    localparam int QD = 2 * `RAMMODEL_MAX_INFLIGHT;
    localparam int QW = $clog2(QD);

    axi_data_t mem [`RAMMODEL_MEM_WORDS];

    axi_addr_t rq_addr [QD];
    axi_len_t  rq_len  [QD];
    axi_id_t   rq_id   [QD];
    logic [QW-1:0] rq_wp, rq_rp;
    axi_len_t  rd_beat;
    logic [WA-1:0] rd_word;
    logic      rd_step;

    axi_addr_t wq_addr [QD];
    logic [QW:0] wq_wp, wq_dp, wq_rp; // push, data, retire
    logic [QW:0] wq_used;
    axi_len_t  wr_beat;
    logic [WA-1:0] wr_word;
    logic      wr_go;

    //////////////////////////////////////////////////////////////////////
    // read bursts
    //////////////////////////////////////////////////////////////////////

    assign rd_word = rq_addr[rq_rp][OFF +: WA] + WA'(rd_beat);
    assign req.rresp_data = mem[rd_word];
    assign req.rresp_last = (rd_beat == rq_len[rq_rp]);
    assign rd_step = req.rreq_valid && (rq_wp != rq_rp) && (req.rreq_id == rq_id[rq_rp]);

    //////////////////////////////////////////////////////////////////////
    // write bursts
    //////////////////////////////////////////////////////////////////////

    assign wq_used = wq_wp - wq_rp;
    assign wr_word = wq_addr[wq_dp[QW-1:0]][OFF +: WA] + WA'(wr_beat);
    assign wr_go   = req.wreq_valid && (wq_dp != wq_wp); // burst open

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rq_wp   <= '0;
            rq_rp   <= '0;
            rd_beat <= '0;
            wq_wp   <= '0;
            wq_dp   <= '0;
            wq_rp   <= '0;
            wr_beat <= '0;
        end else begin
            if (req.areq_valid && !req.areq_write) rq_wp <= rq_wp + 1'b1;
            if (rd_step) begin
                rd_beat <= req.rresp_last ? '0 : rd_beat + 8'd1;
                if (req.rresp_last) rq_rp <= rq_rp + 1'b1;
            end
            if (req.areq_valid && req.areq_write && !wq_used[QW]) wq_wp <= wq_wp + 1'b1;
            if (wr_go) begin
                wr_beat <= req.wreq_last ? '0 : wr_beat + 8'd1;
                if (req.wreq_last) wq_dp <= wq_dp + 1'b1;
            end
            if (req.breq_valid && (wq_rp != wq_dp)) wq_rp <= wq_rp + 1'b1; // slot free
        end
    end

    always_ff @(posedge i_clk) begin
        if (req.areq_valid && !req.areq_write) begin
            rq_addr[rq_wp] <= req.areq_addr;
            rq_len[rq_wp]  <= req.areq_len;
            rq_id[rq_wp]   <= req.areq_id;
        end
        if (req.areq_valid && req.areq_write && !wq_used[QW]) begin
            wq_addr[wq_wp[QW-1:0]] <= req.areq_addr;
        end
        if (wr_go) begin
            for (int b = 0; b < SB; b++) begin
                if (req.wreq_strb[b]) mem[wr_word][8*b +: 8] <= req.wreq_data[8*b +: 8];
            end
        end
    end

endmodule

/* verilog/rammodel_consts.svh */
`ifndef RAMMODEL_CONSTS_SVH
`define RAMMODEL_CONSTS_SVH

// bus geometry
`define RAMMODEL_ADDR_W        16
`define RAMMODEL_DATA_W        64
`define RAMMODEL_ID_W          4

// outstanding bursts per direction, power of two
`define RAMMODEL_MAX_INFLIGHT  4

// fixed latencies in cycles
`define RAMMODEL_R_DELAY       25
`define RAMMODEL_W_DELAY       3

`define RAMMODEL_MEM_WORDS     256 // store depth

`endif

/* verilog/rammodel_delay_queue.sv */
`timescale 1ns/1ps

module rammodel_delay_queue #(
    parameter type T     = logic,
    parameter int  DEPTH = 4,
    parameter int  DELAY = 1
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  T     i_entry,
    output logic o_full,
    output logic o_valid,
    output T     o_entry,
    input  logic i_pop
);

    localparam int PW = $clog2(DEPTH);

    T            entries [DEPTH];
    logic [31:0] stamps  [DEPTH]; // cycle of push
    logic [31:0] now;
    logic [PW:0] wp, rp;
    logic        empty;

    assign empty   = (wp == rp);
    assign o_full  = (wp[PW] != rp[PW]) && (wp[PW-1:0] == rp[PW-1:0]);
    assign o_entry = entries[rp[PW-1:0]];
    // head matures DELAY cycles after its push, stays valid while blocked
    assign o_valid = !empty && ((now - stamps[rp[PW-1:0]]) >= 32'(DELAY));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            now <= '0;
            wp  <= '0;
            rp  <= '0;
        end else begin
            now <= now + 32'd1;
            if (i_push && !o_full) wp <= wp + 1'b1;
            if (o_valid && i_pop)  rp <= rp + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push && !o_full) begin
            entries[wp[PW-1:0]] <= i_entry;
            stamps[wp[PW-1:0]]  <= now;
        end
    end

endmodule

/* verilog/rammodel_frontend.sv */
`timescale 1ns/1ps

module rammodel_frontend import rammodel_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_id_t   i_awid,
    input  axi_addr_t i_awaddr,
    input  axi_len_t  i_awlen,
    input  logic      i_wvalid,
    output logic      o_wready,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    input  logic      i_wlast,
    output logic      o_bvalid,
    input  logic      i_bready,
    output axi_id_t   o_bid,
    input  logic      i_arvalid,
    output logic      o_arready,
    input  axi_id_t   i_arid,
    input  axi_addr_t i_araddr,
    input  axi_len_t  i_arlen,
    output logic      o_rvalid,
    input  logic      i_rready,
    output axi_id_t   o_rid,
    output axi_data_t o_rdata,
    output logic      o_rlast,
    rammodel_req_if.frontend req
);

    logic trk_awvalid, trk_awready, tm_awvalid, tm_awready;
    logic trk_wvalid, trk_wready, tm_wvalid, tm_wready;
    logic trk_arvalid, trk_arready, tm_arvalid, tm_arready;
    logic trk_bvalid, trk_bready, tm_bvalid, tm_bready;
    logic trk_rvalid, trk_rready, tm_rvalid, tm_rready;

    //////////////////////////////////////////////////////////////////////
    // target AW, W, AR out to tracker and timing model
    //////////////////////////////////////////////////////////////////////

    ready_valid_fork #(.BRANCHES(2)) fork_aw_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_awvalid),
        .o_ready (o_awready),
        .o_valid ({tm_awvalid, trk_awvalid}),
        .i_ready ({tm_awready, trk_awready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_w_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_wvalid),
        .o_ready (o_wready),
        .o_valid ({tm_wvalid, trk_wvalid}),
        .i_ready ({tm_wready, trk_wready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_ar_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_arvalid),
        .o_ready (o_arready),
        .o_valid ({tm_arvalid, trk_arvalid}),
        .i_ready ({tm_arready, trk_arready})
    );

    rammodel_tracker tracker_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (trk_awvalid),
        .o_awready (trk_awready),
        .i_awid    (i_awid),
        .i_awaddr  (i_awaddr),
        .i_awlen   (i_awlen),
        .i_wvalid  (trk_wvalid),
        .o_wready  (trk_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_wlast   (i_wlast),
        .i_arvalid (trk_arvalid),
        .o_arready (trk_arready),
        .i_arid    (i_arid),
        .i_araddr  (i_araddr),
        .i_arlen   (i_arlen),
        .i_bvalid  (trk_bvalid),
        .o_bready  (trk_bready),
        .i_rvalid  (trk_rvalid),
        .o_rready  (trk_rready),
        .i_rlast   (req.rresp_last),
        .req       (req)
    );

    rammodel_timing_fixed timing_model_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_arvalid (tm_arvalid),
        .o_arready (tm_arready),
        .i_arid    (i_arid),
        .i_arlen   (i_arlen),
        .i_awvalid (tm_awvalid),
        .o_awready (tm_awready),
        .i_awid    (i_awid),
        .i_wvalid  (tm_wvalid),
        .o_wready  (tm_wready),
        .i_wlast   (i_wlast),
        .o_bvalid  (tm_bvalid),
        .i_bready  (tm_bready),
        .o_bid     (o_bid),
        .o_rvalid  (tm_rvalid),
        .i_rready  (tm_rready),
        .o_rid     (o_rid)
    );

    // store bookkeeping follows the completed responses
    assign req.rreq_valid = tm_rvalid && tm_rready;
    assign req.rreq_id    = o_rid;
    assign req.breq_valid = tm_bvalid && tm_bready;

    assign o_rdata = req.rresp_data;
    assign o_rlast = req.rresp_last;

    //////////////////////////////////////////////////////////////////////
    // timing model B, R back to target and tracker
    //////////////////////////////////////////////////////////////////////

    ready_valid_fork #(.BRANCHES(2)) fork_b_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (tm_bvalid),
        .o_ready (tm_bready),
        .o_valid ({o_bvalid, trk_bvalid}),
        .i_ready ({i_bready, trk_bready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_r_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (tm_rvalid),
        .o_ready (tm_rready),
        .o_valid ({o_rvalid, trk_rvalid}),
        .i_ready ({i_rready, trk_rready})
    );

endmodule

/* verilog/rammodel_pkg.sv */
`include "rammodel_consts.svh"

package rammodel_pkg;

    //////////////////////////////////////////////////////////////////////
    // AXI field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`RAMMODEL_ID_W-1:0]     axi_id_t;
    typedef logic [`RAMMODEL_ADDR_W-1:0]   axi_addr_t;
    typedef logic [`RAMMODEL_DATA_W-1:0]   axi_data_t;
    typedef logic [`RAMMODEL_DATA_W/8-1:0] axi_strb_t;
    typedef logic [7:0]                    axi_len_t; // beats minus one

    //////////////////////////////////////////////////////////////////////
    // timing model queue entries
    //////////////////////////////////////////////////////////////////////

    // pending read burst
    typedef struct packed {
        axi_id_t  id;
        axi_len_t len;
    } rd_entry_t;

    // pending write response
    typedef struct packed {
        axi_id_t id;
    } wr_entry_t;

endpackage

/* verilog/rammodel_req_if.sv */
`timescale 1ns/1ps

interface rammodel_req_if import rammodel_pkg::*; ();

    logic      areq_valid; // one pulse per AW or AR
    logic      areq_write;
    axi_id_t   areq_id;
    axi_addr_t areq_addr;
    axi_len_t  areq_len;

    logic      wreq_valid; // one pulse per W beat
    axi_data_t wreq_data;
    axi_strb_t wreq_strb;
    logic      wreq_last;

    logic      rreq_valid; // R beat completed at the target
    axi_id_t   rreq_id;
    logic      breq_valid; // B completed at the target

    // data for the current read beat
    axi_data_t rresp_data;
    logic      rresp_last;

    modport frontend (
        output areq_valid, areq_write, areq_id, areq_addr, areq_len,
        output wreq_valid, wreq_data, wreq_strb, wreq_last,
        output rreq_valid, rreq_id, breq_valid,
        input  rresp_data, rresp_last
    );

    modport backend (
        input  areq_valid, areq_write, areq_id, areq_addr, areq_len,
        input  wreq_valid, wreq_data, wreq_strb, wreq_last,
        input  rreq_valid, rreq_id, breq_valid,
        output rresp_data, rresp_last
    );

endinterface

/* verilog/rammodel_timing_fixed.sv */
`timescale 1ns/1ps
`include "rammodel_consts.svh"

module rammodel_timing_fixed import rammodel_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_arvalid,
    output logic     o_arready,
    input  axi_id_t  i_arid,
    input  axi_len_t i_arlen,
    input  logic     i_awvalid,
    output logic     o_awready,
    input  axi_id_t  i_awid,
    input  logic     i_wvalid,
    output logic     o_wready,
    input  logic     i_wlast,
    output logic     o_bvalid,
    input  logic     i_bready,
    output axi_id_t  o_bid,
    output logic     o_rvalid,
    input  logic     i_rready,
    output axi_id_t  o_rid
);

    localparam int DEPTH = `RAMMODEL_MAX_INFLIGHT;
    localparam int PW    = $clog2(DEPTH);

    rd_entry_t   rd_new, rd_head;
    wr_entry_t   wr_new, wr_head;
    logic        rd_full, wr_full;
    logic        rd_pop;
    axi_len_t    rd_beat;   // beats already returned for the head burst
    axi_id_t     aw_ids [DEPTH];
    logic [PW:0] aw_wp, aw_rp;
    logic        aw_empty;
    logic        wlast_hs;

    //////////////////////////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////////////////////////

    assign rd_new    = '{id: i_arid, len: i_arlen};
    assign o_arready = !rd_full;
    assign o_rid     = rd_head.id;
    assign rd_pop    = o_rvalid && i_rready && (rd_beat == rd_head.len);

    rammodel_delay_queue #(
        .T     (rd_entry_t),
        .DEPTH (DEPTH),
        .DELAY (`RAMMODEL_R_DELAY)
    ) rd_queue_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_arvalid && o_arready),
        .i_entry (rd_new),
        .o_full  (rd_full),
        .o_valid (o_rvalid),
        .o_entry (rd_head),
        .i_pop   (rd_pop)
    );

    //////////////////////////////////////////////////////////////////////
    // write path
    //////////////////////////////////////////////////////////////////////

    assign aw_empty  = (aw_wp == aw_rp);
    assign o_awready = !((aw_wp[PW] != aw_rp[PW]) && (aw_wp[PW-1:0] == aw_rp[PW-1:0]));
    assign o_wready  = !aw_empty && !wr_full;
    assign wlast_hs  = i_wvalid && o_wready && i_wlast;
    assign wr_new    = '{id: aw_ids[aw_rp[PW-1:0]]}; // oldest open burst
    assign o_bid     = wr_head.id;

    rammodel_delay_queue #(
        .T     (wr_entry_t),
        .DEPTH (DEPTH),
        .DELAY (`RAMMODEL_W_DELAY)
    ) wr_queue_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (wlast_hs),
        .i_entry (wr_new),
        .o_full  (wr_full),
        .o_valid (o_bvalid),
        .o_entry (wr_head),
        .i_pop   (i_bready)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_beat <= '0;
            aw_wp   <= '0;
            aw_rp   <= '0;
        end else begin
            if (o_rvalid && i_rready) rd_beat <= rd_pop ? '0 : rd_beat + 8'd1;
            if (i_awvalid && o_awready) aw_wp <= aw_wp + 1'b1;
            if (wlast_hs) aw_rp <= aw_rp + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_awvalid && o_awready) aw_ids[aw_wp[PW-1:0]] <= i_awid;
    end

endmodule

/* verilog/rammodel_top.sv */
`timescale 1ns/1ps

module rammodel_top import rammodel_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_id_t   i_awid,
    input  axi_addr_t i_awaddr,
    input  axi_len_t  i_awlen,
    input  logic [2:0] i_awsize,  // full width only
    input  logic [1:0] i_awburst, // INCR only
    input  logic      i_wvalid,
    output logic      o_wready,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    input  logic      i_wlast,
    output logic      o_bvalid,
    input  logic      i_bready,
    output axi_id_t   o_bid,
    output logic [1:0] o_bresp,
    input  logic      i_arvalid,
    output logic      o_arready,
    input  axi_id_t   i_arid,
    input  axi_addr_t i_araddr,
    input  axi_len_t  i_arlen,
    input  logic [2:0] i_arsize,
    input  logic [1:0] i_arburst,
    output logic      o_rvalid,
    input  logic      i_rready,
    output axi_id_t   o_rid,
    output axi_data_t o_rdata,
    output logic [1:0] o_rresp,
    output logic      o_rlast
);

    rammodel_req_if req ();

    assign o_bresp = 2'b00; // always OKAY
    assign o_rresp = 2'b00;

    rammodel_frontend frontend_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awid    (i_awid),
        .i_awaddr  (i_awaddr),
        .i_awlen   (i_awlen),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_wlast   (i_wlast),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bid     (o_bid),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_arid    (i_arid),
        .i_araddr  (i_araddr),
        .i_arlen   (i_arlen),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rid     (o_rid),
        .o_rdata   (o_rdata),
        .o_rlast   (o_rlast),
        .req       (req)
    );

    rammodel_backend backend_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .req     (req)
    );

endmodule

/* verilog/rammodel_tracker.sv */
`timescale 1ns/1ps
`include "rammodel_consts.svh"

module rammodel_tracker import rammodel_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_id_t   i_awid,
    input  axi_addr_t i_awaddr,
    input  axi_len_t  i_awlen,
    input  logic      i_wvalid,
    output logic      o_wready,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    input  logic      i_wlast,
    input  logic      i_arvalid,
    output logic      o_arready,
    input  axi_id_t   i_arid,
    input  axi_addr_t i_araddr,
    input  axi_len_t  i_arlen,
    input  logic      i_bvalid,
    output logic      o_bready,
    input  logic      i_rvalid,
    output logic      o_rready,
    input  logic      i_rlast,
    rammodel_req_if.frontend req
);

    localparam int CW = $clog2(`RAMMODEL_MAX_INFLIGHT + 1);

    logic          run;      // low until the first cycle after reset
    logic [CW-1:0] rd_cnt;   // bursts in flight
    logic [CW-1:0] wr_cnt;
    logic [CW-1:0] open_cnt; // write bursts still taking W
    logic          aw_hs, ar_hs, w_hs, b_done, r_done;

    assign o_bready  = 1'b1;
    assign o_rready  = 1'b1;
    assign o_awready = run && (wr_cnt < CW'(`RAMMODEL_MAX_INFLIGHT));
    // one address request per cycle, AW goes first
    assign o_arready = run && (rd_cnt < CW'(`RAMMODEL_MAX_INFLIGHT)) && !i_awvalid;
    assign o_wready  = (open_cnt != '0);

    assign aw_hs  = i_awvalid && o_awready;
    assign ar_hs  = i_arvalid && o_arready;
    assign w_hs   = i_wvalid && o_wready;
    assign b_done = i_bvalid && o_bready;
    assign r_done = i_rvalid && o_rready && i_rlast;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run      <= 1'b0;
            rd_cnt   <= '0;
            wr_cnt   <= '0;
            open_cnt <= '0;
        end else begin
            run      <= 1'b1;
            rd_cnt   <= rd_cnt + CW'(ar_hs) - CW'(r_done);
            wr_cnt   <= wr_cnt + CW'(aw_hs) - CW'(b_done);
            open_cnt <= open_cnt + CW'(aw_hs) - CW'(w_hs && i_wlast);
        end
    end

    // store requests
    assign req.areq_valid = aw_hs || ar_hs;
    assign req.areq_write = aw_hs;
    assign req.areq_id    = aw_hs ? i_awid   : i_arid;
    assign req.areq_addr  = aw_hs ? i_awaddr : i_araddr;
    assign req.areq_len   = aw_hs ? i_awlen  : i_arlen;
    assign req.wreq_valid = w_hs;
    assign req.wreq_data  = i_wdata;
    assign req.wreq_strb  = i_wstrb;
    assign req.wreq_last  = i_wlast;

endmodule

/* verilog/ready_valid_fork.sv */
`timescale 1ns/1ps

module ready_valid_fork #(
    parameter int BRANCHES = 2
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    output logic                o_ready,
    output logic [BRANCHES-1:0] o_valid,
    input  logic [BRANCHES-1:0] i_ready
);

    logic [BRANCHES-1:0] done; // branches that already took this item

    assign o_valid = {BRANCHES{i_valid}} & ~done;
    assign o_ready = &(i_ready | done);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done <= '0;
        end else if (i_valid && o_ready) begin
            done <= '0; // every branch has it, next item
        end else begin
            done <= done | (o_valid & i_ready);
        end
    end

endmodule
